// File: core_block.sv
module core_block import core_pkg::*; (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic [core_id_width-1:0]  core_id,
  dma_wr_if.sink                    dma_wr,
  input  logic                      dma_rd_valid,
  input  logic [dma_addr_width-1:0] dma_rd_addr,
  // Reserved for burst grouping, single-word reads ignore it
  input  logic                      dma_rd_last,
  output logic                      dma_rd_ready,
  output logic                      rd_resp_valid,
  output logic [data_width-1:0]     rd_resp_data,
  input  logic                      rd_resp_ready,
  input  desc_word_u                in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output desc_word_u                out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,
  input  logic [msg_width-1:0]      bc_msg_in,
  input  logic                      bc_msg_in_valid,
  output logic [msg_width-1:0]      bc_msg_out,
  output logic                      bc_msg_out_valid,
  input  logic                      bc_msg_out_ready
);

  logic                       mem_wr_en;
  logic [dma_addr_width-1:0]  mem_wr_addr;
  logic [data_width-1:0]      mem_wr_data;
  logic [strb_width-1:0]      mem_wr_strb;
  logic [bc_offset_width-1:0] bc_offset;
  logic                       rd_fire;
  logic                       desc_is_ctrl;
  logic                       out_desc_free;
  logic                       bc_out_free;
  logic                       pkt_fire;
  logic                       ctrl_fire;

  ////////////////////////////////////////
  // Write port arbitration
  ////////////////////////////////////////
  assign bc_offset    = bc_msg_in[data_width +: bc_offset_width];
  // Broadcast has no ready, so DMA yields
  assign dma_wr.ready = !bc_msg_in_valid;

  always_comb begin
    if (bc_msg_in_valid) begin
      mem_wr_en   = 1'b1;
      mem_wr_addr = dma_addr_width'(bc_region_base + bc_offset);
      mem_wr_data = bc_msg_in[data_width-1:0];
      mem_wr_strb = '1;
    end else begin
      mem_wr_en   = dma_wr.valid;
      mem_wr_addr = dma_wr.addr;
      mem_wr_data = dma_wr.data;
      mem_wr_strb = dma_wr.strb;
    end
  end

  ////////////////////////////////////////
  // DMA read, one in flight
  ////////////////////////////////////////
  assign dma_rd_ready = !rd_resp_valid || rd_resp_ready;
  assign rd_fire      = dma_rd_valid && dma_rd_ready;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      rd_resp_valid <= 1'b0;
    end else if (rd_fire) begin
      rd_resp_valid <= 1'b1;
    end else if (rd_resp_ready) begin
      rd_resp_valid <= 1'b0;
    end
  end

  core_mem i_core_mem (
    .sys_clk (sys_clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .wr_strb (mem_wr_strb),
    .rd_en   (rd_fire),
    .rd_addr (dma_rd_addr),
    .rd_data (rd_resp_data)
  );

  ////////////////////////////////////////
  // Descriptors
  ////////////////////////////////////////
  assign desc_is_ctrl  = in_desc.pkt.kind == desc_kind_ctrl;
  assign out_desc_free = !out_desc_valid || out_desc_ready;
  assign bc_out_free   = !bc_msg_out_valid || bc_msg_out_ready;
  assign in_desc_taken = !in_desc_valid || (desc_is_ctrl ? bc_out_free : out_desc_free);
  assign pkt_fire      = in_desc_valid && !desc_is_ctrl && out_desc_free;
  assign ctrl_fire     = in_desc_valid && desc_is_ctrl && bc_out_free;

  always_ff @(posedge sys_clk) begin
    if (!rst_n) begin
      out_desc_valid   <= 1'b0;
      bc_msg_out_valid <= 1'b0;
    end else begin
      if (pkt_fire) begin
        out_desc_valid <= 1'b1;
      end else if (out_desc_ready) begin
        out_desc_valid <= 1'b0;
      end
      if (ctrl_fire) begin
        bc_msg_out_valid <= 1'b1;
      end else if (bc_msg_out_ready) begin
        bc_msg_out_valid <= 1'b0;
      end
    end
  end

  // Packet goes back stamped with this core's id
  always_ff @(posedge sys_clk) begin
    if (pkt_fire) begin
      out_desc          <= in_desc;
      out_desc.pkt.port <= core_id;
    end
    if (ctrl_fire) begin
      bc_msg_out <= {in_desc.ctrl.msg_addr, in_desc.ctrl.msg_data};
    end
  end

endmodule

// File: core_block_chk.sv
module core_block_chk import core_pkg::*; (
  input logic                  sys_clk,
  input logic                  rst_n_q,
  input logic [desc_width-1:0] out_desc,
  input logic                  out_desc_valid,
  input logic                  out_desc_ready,
  input logic [msg_width-1:0]  bc_msg_out,
  input logic                  bc_msg_out_valid,
  input logic                  bc_msg_out_ready,
  input logic [data_width-1:0] rd_resp_data,
  input logic                  rd_resp_valid,
  input logic                  rd_resp_ready
);

  int fails = 0;

  ////////////////////////////////////////
  // Stalled outputs hold
  ////////////////////////////////////////
  a_out_desc_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_q)
    out_desc_valid && !out_desc_ready |=> out_desc_valid && $stable(out_desc))
    else begin
      $error("out_desc dropped or changed while stalled");
      fails++;
    end

  a_bc_out_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_q)
    bc_msg_out_valid && !bc_msg_out_ready |=> bc_msg_out_valid && $stable(bc_msg_out))
    else begin
      $error("bc_msg_out dropped or changed while stalled");
      fails++;
    end

  a_rd_resp_hold: assert property (@(posedge sys_clk) disable iff (!rst_n_q)
    rd_resp_valid && !rd_resp_ready |=> rd_resp_valid && $stable(rd_resp_data))
    else begin
      $error("rd_resp dropped or changed while stalled");
      fails++;
    end

  // Registered reset clears every output valid
  a_reset_idle: assert property (@(posedge sys_clk)
    !rst_n_q |=> !out_desc_valid && !bc_msg_out_valid && !rd_resp_valid)
    else begin
      $error("output valid high after reset");
      fails++;
    end

endmodule

bind core_block_pr core_block_chk i_core_block_chk (.*);

// File: core_block_pr.f
core_pkg.sv
dma_wr_if.sv
pipe_reg.sv
core_mem.sv
core_block.sv
core_block_pr.sv
core_block_chk.sv
tb_core_block_pr.sv

// File: core_block_pr.sv
module core_block_pr import core_pkg::*; (
  input  logic                      sys_clk,
  input  logic                      rst_n,
  input  logic [core_id_width-1:0]  core_id,

  // DMA
  input  logic                      dma_wr_en,
  input  logic [dma_addr_width-1:0] dma_wr_addr,
  input  logic [data_width-1:0]     dma_wr_data,
  input  logic [strb_width-1:0]     dma_wr_strb,
  input  logic                      dma_wr_last,
  output logic                      dma_wr_ready,
  input  logic                      dma_rd_valid,
  input  logic [dma_addr_width-1:0] dma_rd_addr,
  input  logic                      dma_rd_last,
  output logic                      dma_rd_ready,
  output logic                      rd_resp_valid,
  output logic [data_width-1:0]     rd_resp_data,
  input  logic                      rd_resp_ready,

  // Descriptors
  input  logic [desc_width-1:0]     in_desc,
  input  logic                      in_desc_valid,
  output logic                      in_desc_taken,
  output logic [desc_width-1:0]     out_desc,
  output logic                      out_desc_valid,
  input  logic                      out_desc_ready,

  // Broadcast
  input  logic [msg_width-1:0]      bc_msg_in,
  input  logic                      bc_msg_in_valid,
  output logic [msg_width-1:0]      bc_msg_out,
  output logic                      bc_msg_out_valid,
  input  logic                      bc_msg_out_ready
);

  ////////////////////////////////////////
  // Boundary registers
  ////////////////////////////////////////
  logic                      rst_n_q;
  logic [core_id_width-1:0]  core_id_r;
  logic                      dma_rd_valid_r;
  logic [dma_addr_width-1:0] dma_rd_addr_r;
  logic                      dma_rd_last_r;
  logic                      dma_rd_ready_r;
  logic                      rd_resp_valid_n;
  logic [data_width-1:0]     rd_resp_data_n;
  logic                      rd_resp_ready_n;
  logic [desc_width-1:0]     in_desc_r;
  logic                      in_desc_valid_r;
  logic                      in_desc_taken_r;
  logic [desc_width-1:0]     out_desc_n;
  logic                      out_desc_valid_n;
  logic                      out_desc_ready_n;
  logic [msg_width-1:0]      bc_msg_in_r;
  logic                      bc_msg_in_valid_r;
  logic [msg_width-1:0]      bc_msg_out_n;
  logic                      bc_msg_out_valid_n;
  logic                      bc_msg_out_ready_n;

  dma_wr_if dma_wr ();

  always_ff @(posedge sys_clk) begin
    rst_n_q <= rst_n;
  end

  pipe_reg #(.width(dma_wr_width), .length(reg_length)) i_dma_wr_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  ({dma_wr_addr, dma_wr_data, dma_wr_strb, dma_wr_last}),
    .s_valid (dma_wr_en),
    .s_ready (dma_wr_ready),
    .m_data  ({dma_wr.addr, dma_wr.data, dma_wr.strb, dma_wr.last}),
    .m_valid (dma_wr.valid),
    .m_ready (dma_wr.ready)
  );

  pipe_reg #(.width(dma_rd_width), .length(reg_length)) i_dma_rd_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  ({dma_rd_addr, dma_rd_last}),
    .s_valid (dma_rd_valid),
    .s_ready (dma_rd_ready),
    .m_data  ({dma_rd_addr_r, dma_rd_last_r}),
    .m_valid (dma_rd_valid_r),
    .m_ready (dma_rd_ready_r)
  );

  pipe_reg #(.width(data_width), .length(reg_length)) i_rd_resp_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (rd_resp_data_n),
    .s_valid (rd_resp_valid_n),
    .s_ready (rd_resp_ready_n),
    .m_data  (rd_resp_data),
    .m_valid (rd_resp_valid),
    .m_ready (rd_resp_ready)
  );

  pipe_reg #(.width(desc_width), .length(reg_length)) i_in_desc_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (in_desc),
    .s_valid (in_desc_valid),
    .s_ready (in_desc_taken),
    .m_data  (in_desc_r),
    .m_valid (in_desc_valid_r),
    .m_ready (in_desc_taken_r)
  );

  pipe_reg #(.width(desc_width), .length(reg_length)) i_out_desc_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (out_desc_n),
    .s_valid (out_desc_valid_n),
    .s_ready (out_desc_ready_n),
    .m_data  (out_desc),
    .m_valid (out_desc_valid),
    .m_ready (out_desc_ready)
  );

  // Broadcast input cannot stall
  pipe_reg #(.width(msg_width), .length(reg_length)) i_bc_msg_in_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (bc_msg_in),
    .s_valid (bc_msg_in_valid),
    .s_ready (),
    .m_data  (bc_msg_in_r),
    .m_valid (bc_msg_in_valid_r),
    .m_ready (1'b1)
  );

  pipe_reg #(.width(msg_width), .length(reg_length)) i_bc_msg_out_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (bc_msg_out_n),
    .s_valid (bc_msg_out_valid_n),
    .s_ready (bc_msg_out_ready_n),
    .m_data  (bc_msg_out),
    .m_valid (bc_msg_out_valid),
    .m_ready (bc_msg_out_ready)
  );

  // Static id, registered like every other boundary signal
  pipe_reg #(.width(core_id_width), .length(reg_length)) i_core_id_reg (
    .sys_clk (sys_clk),
    .rst_n   (rst_n_q),
    .s_data  (core_id),
    .s_valid (1'b1),
    .s_ready (),
    .m_data  (core_id_r),
    .m_valid (),
    .m_ready (1'b1)
  );

  ////////////////////////////////////////
  // Core slot
  ////////////////////////////////////////
  core_block i_core_block (
    .sys_clk          (sys_clk),
    .rst_n            (rst_n_q),
    .core_id          (core_id_r),
    .dma_wr           (dma_wr),
    .dma_rd_valid     (dma_rd_valid_r),
    .dma_rd_addr      (dma_rd_addr_r),
    .dma_rd_last      (dma_rd_last_r),
    .dma_rd_ready     (dma_rd_ready_r),
    .rd_resp_valid    (rd_resp_valid_n),
    .rd_resp_data     (rd_resp_data_n),
    .rd_resp_ready    (rd_resp_ready_n),
    .in_desc          (in_desc_r),
    .in_desc_valid    (in_desc_valid_r),
    .in_desc_taken    (in_desc_taken_r),
    .out_desc         (out_desc_n),
    .out_desc_valid   (out_desc_valid_n),
    .out_desc_ready   (out_desc_ready_n),
    .bc_msg_in        (bc_msg_in_r),
    .bc_msg_in_valid  (bc_msg_in_valid_r),
    .bc_msg_out       (bc_msg_out_n),
    .bc_msg_out_valid (bc_msg_out_valid_n),
    .bc_msg_out_ready (bc_msg_out_ready_n)
  );

endmodule

// File: core_mem.sv
module core_mem import core_pkg::*; (
  input  logic                      sys_clk,
  input  logic                      wr_en,
  input  logic [dma_addr_width-1:0] wr_addr,
  input  logic [data_width-1:0]     wr_data,
  input  logic [strb_width-1:0]     wr_strb,
  input  logic                      rd_en,
  input  logic [dma_addr_width-1:0] rd_addr,
  output logic [data_width-1:0]     rd_data
);

  logic [data_width-1:0] mem [0:mem_words-1];

  // Byte lanes written only where strobed
  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      for (int b = 0; b < strb_width; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  // Registered read, old data on a same-address write
  always_ff @(posedge sys_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

// File: core_pkg.sv
package core_pkg;

  ////////////////////////////////////////
  // Data path and memory
  ////////////////////////////////////////
  localparam int data_width     = 32;
  localparam int strb_width     = data_width / 8;
  localparam int dma_addr_width = 8;
  localparam int mem_words      = 2 ** dma_addr_width;
  localparam int core_id_width  = 4;

  // Stages on every boundary path
  localparam int reg_length = 2;

  // Broadcast region is the top quarter of memory
  localparam int bc_region_words = 64;
  localparam int bc_region_base  = mem_words - bc_region_words;
  localparam int bc_offset_width = $clog2(bc_region_words);

  // Broadcast message is {word address, data}
  localparam int msg_addr_width = 8;
  localparam int msg_width      = msg_addr_width + data_width;

  // Packed widths of the boundary paths
  localparam int desc_width   = 64;
  localparam int dma_wr_width = dma_addr_width + data_width + strb_width + 1;
  localparam int dma_rd_width = dma_addr_width + 1;

  ////////////////////////////////////////
  // Descriptor
  ////////////////////////////////////////
  localparam logic desc_kind_ctrl = 1'b1;

  typedef union packed {
    struct packed {
      logic                     kind;
      logic [core_id_width-1:0] port;
      logic [10:0]              tag;
      logic [15:0]              len;
      logic [31:0]              buf_addr;
    } pkt;
    // Control kind carries one outgoing broadcast
    struct packed {
      logic                      kind;
      logic [22:0]               rsvd;
      logic [msg_addr_width-1:0] msg_addr;
      logic [data_width-1:0]     msg_data;
    } ctrl;
  } desc_word_u;

endpackage

// File: dma_wr_if.sv
interface dma_wr_if import core_pkg::*; ();

  logic                      valid;
  logic [dma_addr_width-1:0] addr;
  logic [data_width-1:0]     data;
  logic [strb_width-1:0]     strb;
  logic                      last;
  logic                      ready;

  modport source (
    output valid, addr, data, strb, last,
    input  ready
  );

  modport sink (
    input  valid, addr, data, strb, last,
    output ready
  );

endinterface

// File: pipe_reg.sv
module pipe_reg #(
  parameter int width  = 8,
  parameter int length = 1
) (
  input  logic             sys_clk,
  input  logic             rst_n,
  input  logic [width-1:0] s_data,
  input  logic             s_valid,
  output logic             s_ready,
  output logic [width-1:0] m_data,
  output logic             m_valid,
  input  logic             m_ready
);

  // Index i is the input of stage i, index length the output
  wire [width-1:0] data_c  [0:length];
  wire             valid_c [0:length];
  wire             ready_c [0:length];

  assign data_c[0]       = s_data;
  assign valid_c[0]      = s_valid;
  assign s_ready         = ready_c[0];
  assign m_data          = data_c[length];
  assign m_valid         = valid_c[length];
  assign ready_c[length] = m_ready;

  for (genvar i = 0; i < length; i++) begin : g_stage
    logic [width-1:0] main_data;
    logic             main_valid;
    logic [width-1:0] spare_data;
    logic             spare_valid;

    // Ready comes from a flop, never from downstream ready
    assign ready_c[i]     = !spare_valid;
    assign data_c[i+1]    = main_data;
    assign valid_c[i+1]   = main_valid;

    always_ff @(posedge sys_clk) begin
      if (!rst_n) begin
        main_valid  <= 1'b0;
        spare_valid <= 1'b0;
      end else if (!main_valid || ready_c[i+1]) begin
        // Spare drains first to keep order
        main_valid  <= spare_valid || valid_c[i];
        spare_valid <= 1'b0;
      end else if (valid_c[i] && !spare_valid) begin
        spare_valid <= 1'b1;
      end
    end

    always_ff @(posedge sys_clk) begin
      if (!main_valid || ready_c[i+1]) begin
        main_data <= spare_valid ? spare_data : data_c[i];
      end else if (valid_c[i] && !spare_valid) begin
        spare_data <= data_c[i];
      end
    end
  end

endmodule

// File: tb_core_block_pr.sv
module tb_core_block_pr import core_pkg::*; ();

  logic                      sys_clk;
  logic                      rst_n;
  logic [core_id_width-1:0]  core_id;
  logic                      dma_wr_en;
  logic [dma_addr_width-1:0] dma_wr_addr;
  logic [data_width-1:0]     dma_wr_data;
  logic [strb_width-1:0]     dma_wr_strb;
  logic                      dma_wr_last;
  logic                      dma_wr_ready;
  logic                      dma_rd_valid;
  logic [dma_addr_width-1:0] dma_rd_addr;
  logic                      dma_rd_last;
  logic                      dma_rd_ready;
  logic                      rd_resp_valid;
  logic [data_width-1:0]     rd_resp_data;
  logic                      rd_resp_ready;
  logic [desc_width-1:0]     in_desc;
  logic                      in_desc_valid;
  logic                      in_desc_taken;
  logic [desc_width-1:0]     out_desc;
  logic                      out_desc_valid;
  logic                      out_desc_ready;
  logic [msg_width-1:0]      bc_msg_in;
  logic                      bc_msg_in_valid;
  logic [msg_width-1:0]      bc_msg_out;
  logic                      bc_msg_out_valid;
  logic                      bc_msg_out_ready;

  logic                  run;
  logic [31:0]           lfsr_state;
  logic [data_width-1:0] model_mem [0:mem_words-1];
  bit                    known [0:mem_words-1];
  logic [43:0]           wr_q [$];
  logic [msg_width-1:0]  bc_q [$];
  logic [63:0]           desc_q [$];
  logic [7:0]            rd_q [$];
  logic [31:0]           exp_rd_q [$];
  logic [63:0]           exp_desc_q [$];
  logic [63:0]           exp_msg_q [$];

  core_block_pr i_core_block_pr (.*);

  always #50 sys_clk = ~sys_clk;

  ////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] take_bits(int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] strobe_merge(logic [31:0] old, logic [31:0] d, logic [3:0] s);
    logic [31:0] r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (s[b]) r[b*8 +: 8] = d[b*8 +: 8];
    end
    return r;
  endfunction

  // Control kind gives {addr, data}, packet kind gets the core id as port
  function automatic logic [63:0] predict_desc(logic [63:0] d, logic [3:0] id);
    if (d[63]) begin
      return {24'h0, d[39:32], d[31:0]};
    end
    return {d[63], id, d[58:0]};
  endfunction

  task automatic give_up(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "%s", why);
  endtask

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic step_wait(inout int t, input string what);
    @(negedge sys_clk);
    t++;
    if (t > 2000) give_up({"Timeout: ", what});
  endtask

  task automatic build_stimulus();
    logic [7:0]  a;
    logic [31:0] d;
    logic [3:0]  s;
    logic [63:0] desc;
    for (int i = 0; i < bc_region_base; i++) begin
      a = 8'(i);
      d = {~a, a, a ^ 8'h3c, a + 8'h71};
      wr_q.push_back({a, d, 4'hf});
      model_mem[a] = d;
      known[a] = 1'b1;
    end
    for (int i = 0; i < 64; i++) begin
      a = 8'(take_bits(8) % bc_region_base);
      d = 32'(take_bits(32));
      s = 4'(take_bits(4));
      wr_q.push_back({a, d, s});
      model_mem[a] = strobe_merge(model_mem[a], d, s);
    end
    for (int i = 0; i < 48; i++) begin
      a = 8'(take_bits(6));
      d = 32'(take_bits(32));
      bc_q.push_back({a, d});
      model_mem[bc_region_base + a] = d;
      known[bc_region_base + a] = 1'b1;
    end
    for (int i = 0; i < 40; i++) begin
      desc = take_bits(64);
      desc_q.push_back(desc);
      if (desc[63]) exp_msg_q.push_back(predict_desc(desc, core_id));
      else exp_desc_q.push_back(predict_desc(desc, core_id));
    end
    for (int i = 0; i < mem_words; i++) begin
      if (known[i]) begin
        rd_q.push_back(8'(i));
        exp_rd_q.push_back(model_mem[i]);
      end
    end
  endtask

  ////////////////////////////////////////
  // Drivers, ready read at the falling edge
  ////////////////////////////////////////
  task automatic send_writes();
    int t;
    while (wr_q.size() > 0) begin
      @(negedge sys_clk);
      {dma_wr_addr, dma_wr_data, dma_wr_strb} = wr_q.pop_front();
      dma_wr_en = 1'b1;
      t = 0;
      while (!dma_wr_ready) step_wait(t, "DMA write was never accepted");
    end
    @(negedge sys_clk);
    dma_wr_en = 1'b0;
  endtask

  task automatic send_reads();
    int t;
    while (rd_q.size() > 0) begin
      @(negedge sys_clk);
      dma_rd_addr  = rd_q.pop_front();
      dma_rd_valid = 1'b1;
      t = 0;
      while (!dma_rd_ready) step_wait(t, "DMA read command was never accepted");
    end
    @(negedge sys_clk);
    dma_rd_valid = 1'b0;
  endtask

  task automatic send_descs();
    int t;
    while (desc_q.size() > 0) begin
      @(negedge sys_clk);
      in_desc       = desc_q.pop_front();
      in_desc_valid = 1'b1;
      t = 0;
      while (!in_desc_taken) step_wait(t, "descriptor was never taken");
    end
    @(negedge sys_clk);
    in_desc_valid = 1'b0;
  endtask

  // No ready on this path, one idle cycle between messages
  task automatic send_broadcasts();
    while (bc_q.size() > 0) begin
      @(negedge sys_clk);
      bc_msg_in       = bc_q.pop_front();
      bc_msg_in_valid = 1'b1;
      @(negedge sys_clk);
      bc_msg_in_valid = 1'b0;
    end
  endtask

  // Random readies, then compare whatever transfers on the next rising edge
  always @(negedge sys_clk) begin
    if (run) begin
      rd_resp_ready    = take_bits(2) != 0;
      out_desc_ready   = take_bits(2) != 0;
      bc_msg_out_ready = take_bits(2) != 0;
      if (rd_resp_valid && rd_resp_ready) begin
        if (exp_rd_q.size() == 0) give_up("Unexpected DMA read response");
        compare("dma read", exp_rd_q.pop_front(), rd_resp_data);
      end
      if (out_desc_valid && out_desc_ready) begin
        if (exp_desc_q.size() == 0) give_up("Unexpected descriptor on out_desc");
        compare("packet desc", exp_desc_q.pop_front(), out_desc);
      end
      if (bc_msg_out_valid && bc_msg_out_ready) begin
        if (exp_msg_q.size() == 0) give_up("Unexpected message on bc_msg_out");
        compare("control msg", exp_msg_q.pop_front(), bc_msg_out);
      end
    end
  end

  initial begin
    int t;
    sys_clk = 1'b0;
    rst_n = 1'b0;
    core_id = 4'ha;
    {dma_wr_en, dma_wr_addr, dma_wr_data, dma_wr_strb} = '0;
    {dma_rd_valid, dma_rd_addr, in_desc, in_desc_valid} = '0;
    {bc_msg_in, bc_msg_in_valid} = '0;
    dma_wr_last = 1'b1;
    dma_rd_last = 1'b1;
    {rd_resp_ready, out_desc_ready, bc_msg_out_ready} = 3'b111;
    run = 1'b0;
    lfsr_state = 32'd9;
    build_stimulus();
    repeat (16) @(negedge sys_clk);
    rst_n = 1'b1;
    repeat (2) @(negedge sys_clk);
    compare("reset valids", 0, {rd_resp_valid, out_desc_valid, bc_msg_out_valid});
    compare("reset readies", 3'b111, {dma_wr_ready, dma_rd_ready, in_desc_taken});
    run = 1'b1;
    fork
      send_writes();
      send_broadcasts();
      send_descs();
    join
    // Write path drains once broadcasts stop
    repeat (4 * reg_length + 4) @(negedge sys_clk);
    send_reads();
    t = 0;
    while (exp_rd_q.size() + exp_desc_q.size() + exp_msg_q.size() != 0) begin
      step_wait(t, "expected outputs never arrived");
    end
    repeat (2 * reg_length + 2) @(negedge sys_clk);
    if (i_core_block_pr.i_core_block_chk.fails == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("%0d assertion failures", i_core_block_pr.i_core_block_chk.fails);
      $display("Verification failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule
